//--- hdl/rob_cfg_pkg.sv
`default_nettype none

package rob_cfg_pkg;

    // Register spaces
    localparam int ARCH_REGS  = 32;
    localparam int PHYS_REGS  = 64;

    // Reorder buffer entries
    localparam int ROB_DEPTH  = 16;

    // Every physical register outside the architectural map sits in the free list
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

    localparam int ARCH_W     = $clog2(ARCH_REGS);
    localparam int PHYS_W     = $clog2(PHYS_REGS);
    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);

endpackage

`default_nettype wire

//--- hdl/rob_types_pkg.sv
`default_nettype none

package rob_types_pkg;

    import rob_cfg_pkg::*;

    typedef logic [ARCH_W-1:0]    arch_reg_t;
    typedef logic [PHYS_W-1:0]    phys_reg_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    typedef struct packed {
        logic      valid;
        logic      done;
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
        logic      exception;
        logic      mispred;
    } rob_entry_t;

    // One retired instruction as seen on the commit ports
    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
    } commit_rec_t;

    typedef phys_reg_t [ARCH_REGS-1:0] arch_map_t;

endpackage

`default_nettype wire

//--- hdl/rob_if.sv
`timescale 1ns/1ns
`default_nettype none

// Renamed instructions into the reorder buffer
interface dispatch_if
    import rob_types_pkg::*;
#(
    parameter int DISP_W = 2
) ();

    logic      [DISP_W-1:0] valid;
    logic      [DISP_W-1:0] rd_wen;
    arch_reg_t [DISP_W-1:0] rd_arch;
    phys_reg_t [DISP_W-1:0] new_prf;
    phys_reg_t [DISP_W-1:0] old_prf;
    logic                   space;
    rob_idx_t  [DISP_W-1:0] rob_idx;

    modport producer (output valid, rd_wen, rd_arch, new_prf, old_prf, input space, rob_idx);
    modport buffer (input valid, rd_wen, rd_arch, new_prf, old_prf, output space, rob_idx);

endinterface

// Registered retirement group and flush pulse
interface commit_if
    import rob_types_pkg::*;
#(
    parameter int COMMIT_W = 2
) ();

    logic      [COMMIT_W-1:0] valid;
    logic      [COMMIT_W-1:0] rd_wen;
    arch_reg_t [COMMIT_W-1:0] rd_arch;
    phys_reg_t [COMMIT_W-1:0] new_prf;
    phys_reg_t [COMMIT_W-1:0] old_prf;
    logic                     flush;
    rob_idx_t                 flush_idx;

    modport driver (output valid, rd_wen, rd_arch, new_prf, old_prf, flush, flush_idx);
    modport committer (input valid, rd_wen, rd_arch, new_prf, old_prf);
    modport observer (input flush);

endinterface

`default_nettype wire

//--- hdl/rename_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rename_stage
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
#(
    parameter int DISP_W   = 2,
    parameter int COMMIT_W = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic      [DISP_W-1:0]   disp_valid_i,
    input  logic      [DISP_W-1:0]   disp_rd_wen_i,
    input  arch_reg_t [DISP_W-1:0]   disp_rd_arch_i,
    input  logic      [COMMIT_W-1:0] free_valid_i,
    input  phys_reg_t [COMMIT_W-1:0] free_prf_i,
    input  arch_map_t                arch_map_i,
    output logic                     disp_ready_o,
    dispatch_if.producer             disp,
    commit_if.observer               cm
);

    localparam int FIDX_W = $clog2(FREE_DEPTH);
    localparam int FPTR_W = FIDX_W + 1;

    typedef logic [FPTR_W-1:0] fptr_t;

    arch_map_t   spec_map;
    arch_map_t   spec_map_n;
    phys_reg_t   free_list [FREE_DEPTH];
    fptr_t       spec_head;
    fptr_t       spec_head_n;
    fptr_t       ret_head;
    fptr_t       tail;
    fptr_t       tail_n;
    fptr_t       push_ptr [COMMIT_W];
    fptr_t       avail;
    logic        restore_q;
    logic [DISP_W-1:0] fire;

    assign avail = tail - spec_head;

    // Blocked during the flush pulse and the restore cycle after it
    assign disp_ready_o = disp.space && (avail >= fptr_t'(DISP_W)) && !cm.flush && !restore_q;

    assign fire       = disp_valid_i & {DISP_W{disp_ready_o}};
    assign disp.valid = fire;

    // Later lanes see mappings made by earlier lanes
    always_comb begin
        spec_map_n  = spec_map;
        spec_head_n = spec_head;
        for (int i = 0; i < DISP_W; i++) begin
            disp.rd_wen[i]  = disp_rd_wen_i[i];
            disp.rd_arch[i] = disp_rd_arch_i[i];
            disp.old_prf[i] = spec_map_n[disp_rd_arch_i[i]];
            if (fire[i] && disp_rd_wen_i[i]) begin
                disp.new_prf[i] = free_list[spec_head_n[FIDX_W-1:0]];
                spec_map_n[disp_rd_arch_i[i]] = free_list[spec_head_n[FIDX_W-1:0]];
                spec_head_n = spec_head_n + 1'b1;
            end else begin
                // No destination, mapping stays as it is
                disp.new_prf[i] = spec_map_n[disp_rd_arch_i[i]];
            end
        end
    end

    // Released registers go in at the tail, skipping idle lanes
    always_comb begin
        tail_n = tail;
        for (int i = 0; i < COMMIT_W; i++) begin
            push_ptr[i] = tail_n;
            if (free_valid_i[i]) begin
                tail_n = tail_n + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= phys_reg_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            spec_head <= '0;
            ret_head  <= '0;
            tail      <= fptr_t'(FREE_DEPTH);
            restore_q <= 1'b0;
        end else begin
            restore_q <= cm.flush;
            if (restore_q) begin
                spec_map  <= arch_map_i;
                spec_head <= ret_head;
            end else begin
                spec_map  <= spec_map_n;
                spec_head <= spec_head_n;
            end
            for (int i = 0; i < COMMIT_W; i++) begin
                if (free_valid_i[i]) begin
                    free_list[push_ptr[i][FIDX_W-1:0]] <= free_prf_i[i];
                end
            end
            tail <= tail_n;
            // One committed allocation per release
            ret_head <= ret_head + (tail_n - tail);
        end
    end

endmodule

`default_nettype wire

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
#(
    parameter int DISP_W   = 2,
    parameter int COMMIT_W = 2,
    parameter int WB_W     = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic     [WB_W-1:0]  wb_valid_i,
    input  rob_idx_t [WB_W-1:0]  wb_idx_i,
    input  logic     [WB_W-1:0]  wb_exception_i,
    input  logic     [WB_W-1:0]  wb_mispred_i,
    dispatch_if.buffer           disp,
    commit_if.driver             cm
);

    typedef logic [ROB_IDX_W:0] cnt_t;

    rob_entry_t          rob_q [ROB_DEPTH];
    rob_idx_t            head;
    rob_idx_t            tail;
    rob_idx_t            tail_n;
    cnt_t                count;
    cnt_t                n_alloc;
    cnt_t                n_retire;
    rob_idx_t            ridx [COMMIT_W];
    logic [COMMIT_W-1:0] retire_en;
    logic                flush_n;
    rob_idx_t            flush_idx_n;
    logic                stop;

    assign disp.space = (cnt_t'(ROB_DEPTH) - count) >= cnt_t'(DISP_W);

    // Allocation in lane order
    always_comb begin
        tail_n  = tail;
        n_alloc = '0;
        for (int i = 0; i < DISP_W; i++) begin
            disp.rob_idx[i] = tail_n;
            if (disp.valid[i]) begin
                tail_n  = tail_n + 1'b1;
                n_alloc = n_alloc + 1'b1;
            end
        end
    end

    // Retire a contiguous run of done entries from the head
    always_comb begin
        retire_en   = '0;
        n_retire    = '0;
        flush_n     = 1'b0;
        flush_idx_n = head;
        stop        = 1'b0;
        for (int i = 0; i < COMMIT_W; i++) begin
            ridx[i] = head + rob_idx_t'(i);
            if (!stop && rob_q[ridx[i]].valid && rob_q[ridx[i]].done) begin
                retire_en[i] = 1'b1;
                n_retire     = n_retire + 1'b1;
                // A flagged entry closes the group
                if (rob_q[ridx[i]].exception || rob_q[ridx[i]].mispred) begin
                    flush_n     = 1'b1;
                    flush_idx_n = ridx[i];
                    stop        = 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            cm.valid <= '0;
            cm.flush <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob_q[i].valid <= 1'b0;
                rob_q[i].done  <= 1'b0;
            end
        end else begin
            for (int i = 0; i < WB_W; i++) begin
                if (wb_valid_i[i]) begin
                    rob_q[wb_idx_i[i]].done      <= 1'b1;
                    rob_q[wb_idx_i[i]].exception <= wb_exception_i[i];
                    rob_q[wb_idx_i[i]].mispred   <= wb_mispred_i[i];
                end
            end
            for (int i = 0; i < DISP_W; i++) begin
                if (disp.valid[i]) begin
                    rob_q[disp.rob_idx[i]] <= '{valid:     1'b1,
                                               done:      1'b0,
                                               rd_wen:    disp.rd_wen[i],
                                               rd_arch:   disp.rd_arch[i],
                                               new_prf:   disp.new_prf[i],
                                               old_prf:   disp.old_prf[i],
                                               exception: 1'b0,
                                               mispred:   1'b0};
                end
            end
            for (int i = 0; i < COMMIT_W; i++) begin
                if (retire_en[i]) begin
                    rob_q[ridx[i]].valid <= 1'b0;
                end
            end
            cm.valid <= retire_en;
            cm.flush <= flush_n;
            if (flush_n) begin
                // Younger entries, including this cycle's dispatch, are dropped
                head  <= '0;
                tail  <= '0;
                count <= '0;
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    rob_q[i].valid <= 1'b0;
                end
            end else begin
                head  <= head + n_retire[ROB_IDX_W-1:0];
                tail  <= tail_n;
                count <= count + n_alloc - n_retire;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < COMMIT_W; i++) begin
            cm.rd_wen[i]  <= rob_q[ridx[i]].rd_wen;
            cm.rd_arch[i] <= rob_q[ridx[i]].rd_arch;
            cm.new_prf[i] <= rob_q[ridx[i]].new_prf;
            cm.old_prf[i] <= rob_q[ridx[i]].old_prf;
        end
        cm.flush_idx <= flush_idx_n;
    end

endmodule

`default_nettype wire

//--- hdl/commit_stage.sv
`timescale 1ns/1ns
`default_nettype none

module commit_stage
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
#(
    parameter int COMMIT_W = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    commit_if.committer              cm,
    output logic      [COMMIT_W-1:0] commit_valid_o,
    output logic      [COMMIT_W-1:0] commit_rd_wen_o,
    output arch_reg_t [COMMIT_W-1:0] commit_rd_arch_o,
    output phys_reg_t [COMMIT_W-1:0] commit_new_prf_o,
    output phys_reg_t [COMMIT_W-1:0] commit_old_prf_o,
    output logic      [COMMIT_W-1:0] free_valid_o,
    output phys_reg_t [COMMIT_W-1:0] free_prf_o,
    output arch_map_t                arch_map_o
);

    arch_map_t           arch_map_q;
    logic [COMMIT_W-1:0] map_wr;

    // Only lanes with a destination touch the map
    assign map_wr = cm.valid & cm.rd_wen;

    // The replaced mapping is free once its writer commits
    assign free_valid_o = map_wr;
    assign free_prf_o   = cm.old_prf;

    assign commit_valid_o   = cm.valid;
    assign commit_rd_wen_o  = cm.rd_wen;
    assign commit_rd_arch_o = cm.rd_arch;
    assign commit_new_prf_o = cm.new_prf;
    assign commit_old_prf_o = cm.old_prf;

    assign arch_map_o = arch_map_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                arch_map_q[i] <= phys_reg_t'(i);
            end
        end else begin
            // Later lane wins on the same destination
            for (int i = 0; i < COMMIT_W; i++) begin
                if (map_wr[i]) begin
                    arch_map_q[cm.rd_arch[i]] <= cm.new_prf[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/retire_unit.sv
`timescale 1ns/1ns
`default_nettype none

module retire_unit
    import rob_types_pkg::*;
#(
    parameter int DISP_W   = 2,
    parameter int COMMIT_W = 2,
    parameter int WB_W     = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic      [DISP_W-1:0]   disp_valid_i,
    input  logic      [DISP_W-1:0]   disp_rd_wen_i,
    input  arch_reg_t [DISP_W-1:0]   disp_rd_arch_i,
    output logic                     disp_ready_o,
    output rob_idx_t  [DISP_W-1:0]   disp_idx_o,
    input  logic      [WB_W-1:0]     wb_valid_i,
    input  rob_idx_t  [WB_W-1:0]     wb_idx_i,
    input  logic      [WB_W-1:0]     wb_exception_i,
    input  logic      [WB_W-1:0]     wb_mispred_i,
    output logic      [COMMIT_W-1:0] commit_valid_o,
    output logic      [COMMIT_W-1:0] commit_rd_wen_o,
    output arch_reg_t [COMMIT_W-1:0] commit_rd_arch_o,
    output phys_reg_t [COMMIT_W-1:0] commit_new_prf_o,
    output phys_reg_t [COMMIT_W-1:0] commit_old_prf_o,
    output logic                     flush_o,
    output rob_idx_t                 flush_idx_o
);

    logic      [COMMIT_W-1:0] free_valid;
    phys_reg_t [COMMIT_W-1:0] free_prf;
    arch_map_t                arch_map;

    dispatch_if #(.DISP_W(DISP_W))     disp_bus ();
    commit_if   #(.COMMIT_W(COMMIT_W)) commit_bus ();

    assign disp_idx_o  = disp_bus.rob_idx;
    assign flush_o     = commit_bus.flush;
    assign flush_idx_o = commit_bus.flush_idx;

    rename_stage #(
        .DISP_W   (DISP_W),
        .COMMIT_W (COMMIT_W)
    ) rename_i (
        .clk            (clk),
        .reset          (reset),
        .disp_valid_i   (disp_valid_i),
        .disp_rd_wen_i  (disp_rd_wen_i),
        .disp_rd_arch_i (disp_rd_arch_i),
        .free_valid_i   (free_valid),
        .free_prf_i     (free_prf),
        .arch_map_i     (arch_map),
        .disp_ready_o   (disp_ready_o),
        .disp           (disp_bus.producer),
        .cm             (commit_bus.observer)
    );

    reorder_buffer #(
        .DISP_W   (DISP_W),
        .COMMIT_W (COMMIT_W),
        .WB_W     (WB_W)
    ) rob_i (
        .clk            (clk),
        .reset          (reset),
        .wb_valid_i     (wb_valid_i),
        .wb_idx_i       (wb_idx_i),
        .wb_exception_i (wb_exception_i),
        .wb_mispred_i   (wb_mispred_i),
        .disp           (disp_bus.buffer),
        .cm             (commit_bus.driver)
    );

    commit_stage #(
        .COMMIT_W (COMMIT_W)
    ) commit_i (
        .clk              (clk),
        .reset            (reset),
        .cm               (commit_bus.committer),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_wen_o  (commit_rd_wen_o),
        .commit_rd_arch_o (commit_rd_arch_o),
        .commit_new_prf_o (commit_new_prf_o),
        .commit_old_prf_o (commit_old_prf_o),
        .free_valid_o     (free_valid),
        .free_prf_o       (free_prf),
        .arch_map_o       (arch_map)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- tb/tb_retire_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_retire_unit
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
;

    logic clk;
    logic reset;
    logic [1:0] disp_valid_i, disp_rd_wen_i;
    arch_reg_t [1:0] disp_rd_arch_i;
    logic disp_ready_o;
    rob_idx_t [1:0] disp_idx_o;
    logic [1:0] wb_valid_i, wb_exception_i, wb_mispred_i;
    rob_idx_t [1:0] wb_idx_i;
    logic [1:0] commit_valid_o, commit_rd_wen_o;
    arch_reg_t [1:0] commit_rd_arch_o;
    phys_reg_t [1:0] commit_new_prf_o, commit_old_prf_o;
    logic flush_o;
    rob_idx_t flush_idx_o;

    logic [31:0] rng = 32'hdf2d_6b0d;
    rob_idx_t q_idx[$];
    logic q_wen[$];
    arch_reg_t q_arch[$];
    phys_reg_t q_new[$];
    rob_idx_t pending[$];
    phys_reg_t free_q[$];
    logic flagged [ROB_DEPTH];
    arch_map_t tb_map;
    string test_name = "reset";
    int accepted, target, progress, flushes, err_count, bp_count;
    int spec_off;
    int wb_limit;
    logic disp_on, wb_on, flags_on, bp_mode, prev_flush;

    tb_clock #(.PERIOD(40)) clock_i (.clk_o(clk));

    retire_unit dut_i (.*);

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Old mapping comes from the committed map
    function automatic commit_rec_t expected_commit(input logic wen, input arch_reg_t arch,
                                                    input phys_reg_t alloc_prf,
                                                    input arch_map_t map);
        commit_rec_t rec;
        rec.rd_wen  = wen;
        rec.rd_arch = arch;
        rec.old_prf = map[arch];
        rec.new_prf = wen ? alloc_prf : map[arch];
        return rec;
    endfunction

    task automatic fail_run(input string msg);
        err_count++;
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_commit(input string name, input commit_rec_t exp, input commit_rec_t act);
        if (exp !== act)
            fail_run($sformatf("Error %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flush(input string name, input rob_idx_t exp, input rob_idx_t act);
        if (exp !== act)
            fail_run($sformatf("Error %s: flush index expected %0d actual %0d", name, exp, act));
    endtask

    // Waits on a progress counter, so a stall of 2000 cycles is the timeout
    task automatic wait_drained();
        int last;
        int idle;
        last = progress;
        idle = 0;
        while (q_idx.size() != 0 || pending.size() != 0) begin
            @(negedge clk);
            if (progress != last) begin
                last = progress;
                idle = 0;
            end else if (++idle >= 2000) begin
                fail_run($sformatf("%s: timeout while draining the reorder buffer", test_name));
            end
        end
    endtask

    task automatic run_traffic(input int n);
        int idle;
        idle = 0;
        target = accepted + n;
        wb_on = 1'b1;
        disp_on = 1'b1;
        while (accepted < target) begin
            @(negedge clk);
            if (++idle >= 2000)
                fail_run($sformatf("%s: timeout waiting for dispatch", test_name));
        end
        disp_on = 1'b0;
        wait_drained();
    endtask

    // Stimulus
    always @(posedge clk) begin
        logic [31:0] r;
        int k;
        int span;
        logic flag;
        if (!reset) begin
            for (int l = 0; l < 2; l++) begin
                r = next_rand();
                disp_valid_i[l]   <= disp_on && (accepted < target) && (bp_mode || r[0]);
                disp_rd_wen_i[l]  <= (r[3:1] != 3'd0);
                disp_rd_arch_i[l] <= r[8:4];
                wb_valid_i[l]     <= 1'b0;
                span = (wb_limit < 0) ? pending.size() : wb_limit;
                if (wb_on && span > 0 && r[11:9] != 3'd0) begin
                    k = int'(r[31:20]) % span;
                    flag = flags_on && r[15:12] == 4'd0;
                    wb_idx_i[l]       <= pending[k];
                    wb_valid_i[l]     <= 1'b1;
                    wb_exception_i[l] <= flag && r[16];
                    wb_mispred_i[l]   <= flag && !r[16];
                    flagged[pending[k]] = flag;
                    pending.delete(k);
                    // Only entries older than a flagged one still get a writeback
                    if (flag)
                        wb_limit = k;
                    else if (wb_limit > 0)
                        wb_limit--;
                end
            end
        end
    end

    // Checker, sampled where all DUT outputs are stable
    always @(negedge clk) begin
        commit_rec_t exp_rec;
        commit_rec_t act_rec;
        rob_idx_t last_idx;
        logic flag_seen;
        if (!reset) begin
            flag_seen = 1'b0;
            if (prev_flush && disp_ready_o)
                fail_run($sformatf("%s: dispatch ready during restore", test_name));
            for (int l = 0; l < 2; l++) begin
                if (commit_valid_o[l]) begin
                    if (l == 1 && !commit_valid_o[0])
                        fail_run($sformatf("%s: lane 1 committed without lane 0", test_name));
                    if (flag_seen)
                        fail_run($sformatf("%s: instruction committed after a flagged one",
                                           test_name));
                    if (q_idx.size() == 0)
                        fail_run($sformatf("%s: commit with nothing outstanding", test_name));
                    act_rec = '{commit_rd_wen_o[l], commit_rd_arch_o[l],
                                commit_new_prf_o[l], commit_old_prf_o[l]};
                    exp_rec = expected_commit(q_wen[0], q_arch[0], q_new[0], tb_map);
                    check_commit(test_name, exp_rec, act_rec);
                    if (act_rec.rd_wen) begin
                        for (int j = 0; j < ARCH_REGS; j++)
                            if (j != act_rec.rd_arch && tb_map[j] == act_rec.new_prf)
                                fail_run($sformatf("%s: new register %0d already mapped",
                                                   test_name, act_rec.new_prf));
                        tb_map[act_rec.rd_arch] = act_rec.new_prf;
                        // Retired head moves past the committed register
                        void'(free_q.pop_front());
                        free_q.push_back(exp_rec.old_prf);
                        spec_off--;
                    end
                    last_idx = q_idx.pop_front();
                    void'(q_wen.pop_front());
                    void'(q_arch.pop_front());
                    void'(q_new.pop_front());
                    flag_seen = flagged[last_idx];
                    progress++;
                end
            end
            if (flush_o !== flag_seen)
                fail_run($sformatf("%s: flush pulse does not match the flagged commit",
                                   test_name));
            if (flush_o) begin
                check_flush(test_name, last_idx, flush_idx_o);
                if (disp_ready_o)
                    fail_run($sformatf("%s: dispatch ready in the flush cycle", test_name));
                // Everything still queued is younger than the flagged one
                q_idx.delete();
                q_wen.delete();
                q_arch.delete();
                q_new.delete();
                pending.delete();
                // Renaming restarts from the retired head
                spec_off = 0;
                wb_limit = -1;
                flushes++;
            end
            prev_flush = flush_o;
            for (int l = 0; l < 2; l++) begin
                if (disp_valid_i[l] && disp_ready_o) begin
                    q_idx.push_back(disp_idx_o[l]);
                    q_wen.push_back(disp_rd_wen_i[l]);
                    q_arch.push_back(disp_rd_arch_i[l]);
                    if (disp_rd_wen_i[l]) begin
                        q_new.push_back(free_q[spec_off]);
                        spec_off++;
                    end else begin
                        q_new.push_back(phys_reg_t'(0));
                    end
                    pending.push_back(disp_idx_o[l]);
                    accepted++;
                    bp_count++;
                    progress++;
                end
            end
        end
    end

    initial begin
        int idle;
        reset = 1'b1;
        disp_valid_i = '0;
        disp_rd_wen_i = '0;
        disp_rd_arch_i = '0;
        wb_valid_i = '0;
        wb_idx_i = '0;
        wb_exception_i = '0;
        wb_mispred_i = '0;
        {disp_on, wb_on, flags_on, bp_mode, prev_flush} = '0;
        for (int i = 0; i < ARCH_REGS; i++)
            tb_map[i] = phys_reg_t'(i);
        for (int i = 0; i < FREE_DEPTH; i++)
            free_q.push_back(phys_reg_t'(ARCH_REGS + i));
        spec_off = 0;
        wb_limit = -1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        test_name = "in_order";
        run_traffic(100);

        // Writebacks held back until the buffer fills
        test_name = "back_pressure";
        wb_on = 1'b0;
        bp_mode = 1'b1;
        bp_count = 0;
        target = accepted + 4 * ROB_DEPTH;
        disp_on = 1'b1;
        idle = 0;
        while (disp_ready_o || bp_count == 0) begin
            @(negedge clk);
            if (++idle >= 2000)
                fail_run("back_pressure: timeout waiting for dispatch ready to fall");
        end
        disp_on = 1'b0;
        bp_mode = 1'b0;
        if (bp_count != ROB_DEPTH)
            fail_run($sformatf("Error back_pressure: expected %0d actual %0d",
                               ROB_DEPTH, bp_count));
        wb_on = 1'b1;
        wait_drained();
        run_traffic(20);

        test_name = "recycle";
        flags_on = 1'b1;
        run_traffic(400);
        if (flushes == 0)
            fail_run("recycle: no flush occurred");

        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "errors found");
        end
    end

endmodule

`default_nettype wire

//--- retire_unit.f
hdl/rob_cfg_pkg.sv
hdl/rob_types_pkg.sv
hdl/rob_if.sv
hdl/rename_stage.sv
hdl/reorder_buffer.sv
hdl/commit_stage.sv
hdl/retire_unit.sv
tb/tb_clock.sv
tb/tb_retire_unit.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_retire_unit
FILELIST  = retire_unit.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
